// ==== logic/tcdm_pkg.sv ====
// tcdm slice shared widths, data vector types and arbiter state encoding
package tcdm_pkg;

  // word and byte-enable widths of a bank port
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;  // one enable per byte

  localparam int unsigned STALL_W = 8;  // width of the starvation counter

  // read and write data of every channel
  typedef logic [DATA_W-1:0] data_t;

  // byte enables for partial writes
  typedef logic [BE_W-1:0] be_t;

  // max stall control and stall counter
  typedef logic [STALL_W-1:0] stall_cnt_t;

  // arbiter side selection state
  typedef enum logic {
    ARB_PRIO  = 1'b0,  // priority side wins where it requests
    ARB_YIELD = 1'b1   // forced win for the other side this cycle
  } arb_state_e;

endpackage

// ==== logic/tcdm_arbiter.sv ====
// two-port bank arbiter with default priority side and starvation stall counter
`timescale 1ns/100ps

module tcdm_arbiter #(
  parameter int unsigned NB_CHAN = 2,
  parameter int unsigned ADDR_W  = 6
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 invert_prio_i,  // lo side becomes priority
  input  tcdm_pkg::stall_cnt_t max_stall_i,    // 0 disables the guard

  // hi side (cores by default)
  input  logic [NB_CHAN-1:0]   hi_req_i,
  input  logic [ADDR_W-1:0]    hi_add_i  [NB_CHAN],
  input  logic [NB_CHAN-1:0]   hi_wen_i,
  input  tcdm_pkg::be_t        hi_be_i   [NB_CHAN],
  input  tcdm_pkg::data_t      hi_data_i [NB_CHAN],

  // lo side (accelerator by default)
  input  logic [NB_CHAN-1:0]   lo_req_i,
  input  logic [ADDR_W-1:0]    lo_add_i  [NB_CHAN],
  input  logic [NB_CHAN-1:0]   lo_wen_i,
  input  tcdm_pkg::be_t        lo_be_i   [NB_CHAN],
  input  tcdm_pkg::data_t      lo_data_i [NB_CHAN],

  output logic [NB_CHAN-1:0]   hi_gnt_o,
  output logic [NB_CHAN-1:0]   lo_gnt_o,

  // toward the banks
  output logic [NB_CHAN-1:0]   bank_req_o,
  output logic [NB_CHAN-1:0]   bank_wen_o,
  output logic [ADDR_W-1:0]    bank_add_o  [NB_CHAN],
  output tcdm_pkg::be_t        bank_be_o   [NB_CHAN],
  output tcdm_pkg::data_t      bank_data_o [NB_CHAN],
  output logic [NB_CHAN-1:0]   sel_lo_o    // 1 when lo port is routed
);

  logic [NB_CHAN-1:0]   prio_req;   // requests of the priority role
  logic [NB_CHAN-1:0]   np_req;     // requests of the non-priority role
  logic [NB_CHAN-1:0]   sel_np;     // non-priority role routed
  logic                 contested;  // some channel has both sides up
  logic                 yield;

  tcdm_pkg::arb_state_e state_q, state_d;
  tcdm_pkg::stall_cnt_t cnt_q, cnt_d;

  // priority roles follow invert_prio_i
  assign prio_req  = invert_prio_i ? lo_req_i : hi_req_i;
  assign np_req    = invert_prio_i ? hi_req_i : lo_req_i;
  assign contested = |(prio_req & np_req);
  assign yield     = (state_q == tcdm_pkg::ARB_YIELD);

  // starvation fsm counts prio wins under contention and then yields once
  always_comb
  begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      tcdm_pkg::ARB_PRIO:
      begin
        if (contested)
        begin
          cnt_d = (cnt_q == '1) ? cnt_q : cnt_q + 1'b1;  // saturate
          if ((max_stall_i != '0) && (cnt_d >= max_stall_i))
            state_d = tcdm_pkg::ARB_YIELD;  // next cycle goes to the other side
        end
        else
          cnt_d = '0;  // idle or single-sided cycle breaks the run
      end
      tcdm_pkg::ARB_YIELD:
      begin
        cnt_d   = '0;  // forced cycle restarts the count
        state_d = tcdm_pkg::ARB_PRIO;
      end
      default: state_d = tcdm_pkg::ARB_PRIO;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= tcdm_pkg::ARB_PRIO;
      cnt_q   <= '0;
    end
    else if (clear_i)
    begin
      state_q <= tcdm_pkg::ARB_PRIO;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // non-priority side passes on yield or when priority side is idle
  assign sel_np   = {NB_CHAN{yield}} | ~prio_req;
  assign sel_lo_o = sel_np ^ {NB_CHAN{invert_prio_i}};  // back to hi/lo naming

  for (genvar c = 0; c < NB_CHAN; c++)
  begin : g_chan
    // only the routed side sees a grant
    assign hi_gnt_o[c] = hi_req_i[c] & ~sel_lo_o[c];
    assign lo_gnt_o[c] = lo_req_i[c] &  sel_lo_o[c];

    assign bank_req_o[c]  = hi_gnt_o[c] | lo_gnt_o[c];
    assign bank_wen_o[c]  = sel_lo_o[c] ? lo_wen_i[c]  : hi_wen_i[c];
    assign bank_add_o[c]  = sel_lo_o[c] ? lo_add_i[c]  : hi_add_i[c];
    assign bank_be_o[c]   = sel_lo_o[c] ? lo_be_i[c]   : hi_be_i[c];
    assign bank_data_o[c] = sel_lo_o[c] ? lo_data_i[c] : hi_data_i[c];
  end

  // count stays below a steady limit unless this is the forced cycle
  a_cnt_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((max_stall_i != '0) && $stable(max_stall_i) && !yield) |-> (cnt_q < max_stall_i))
    else $error("stall counter reached max_stall_i without a yield");

endmodule

// ==== logic/tcdm_bank.sv ====
// single-port sram bank with byte-enable writes and one-cycle registered reads
`timescale 1ns/100ps

module tcdm_bank #(
  parameter int unsigned ADDR_W = 6
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  logic            wen_i,     // 1 = write
  input  logic [ADDR_W-1:0] add_i,   // word address
  input  tcdm_pkg::be_t   be_i,
  input  tcdm_pkg::data_t data_i,
  output tcdm_pkg::data_t r_data_o
);

  localparam int unsigned NB_WORDS = 2 ** ADDR_W;

  tcdm_pkg::data_t mem [NB_WORDS];  // storage array
  tcdm_pkg::data_t r_data_q;        // read port register

  logic wr_en;
  logic rd_en;

  assign wr_en = req_i &  wen_i;
  assign rd_en = req_i & ~wen_i;

  // byte-merged write, lands on the edge closing the grant cycle
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < tcdm_pkg::BE_W; b++)
      begin
        if (be_i[b])
          mem[add_i][8*b +: 8] <= data_i[8*b +: 8];
      end
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      r_data_q <= '0;
    else if (rd_en)
      r_data_q <= mem[add_i];
  end

  assign r_data_o = r_data_q;

  // address must be driven on every access
  a_add_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown(add_i))
    else $error("bank address unknown during request");

endmodule

// ==== logic/tcdm_resp_route.sv ====
// response router returning the bank response valid to the side that won
`timescale 1ns/100ps

module tcdm_resp_route #(
  parameter int unsigned NB_CHAN = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic [NB_CHAN-1:0] bank_req_i,   // bank accessed this cycle
  input  logic [NB_CHAN-1:0] sel_lo_i,     // lo side won this cycle
  input  tcdm_pkg::data_t    bank_r_data_i [NB_CHAN],
  output logic [NB_CHAN-1:0] hi_r_valid_o,
  output logic [NB_CHAN-1:0] lo_r_valid_o,
  output tcdm_pkg::data_t    hi_r_data_o   [NB_CHAN],
  output tcdm_pkg::data_t    lo_r_data_o   [NB_CHAN]
);

  logic [NB_CHAN-1:0] req_q;     // access one cycle ago
  logic [NB_CHAN-1:0] sel_lo_q;  // winner one cycle ago

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      req_q    <= '0;
      sel_lo_q <= '0;
    end
    else if (clear_i)
    begin
      req_q    <= '0;
      sel_lo_q <= '0;
    end
    else
    begin
      req_q    <= bank_req_i;
      sel_lo_q <= sel_lo_i;
    end
  end

  // valid on reads and writes alike
  assign hi_r_valid_o = req_q & ~sel_lo_q;
  assign lo_r_valid_o = req_q &  sel_lo_q;

  for (genvar c = 0; c < NB_CHAN; c++)
  begin : g_chan
    assign hi_r_data_o[c] = bank_r_data_i[c];  // same data to both sides
    assign lo_r_data_o[c] = bank_r_data_i[c];
  end

endmodule

// ==== logic/tcdm_subsys.sv ====
// tcdm slice top: hi/lo arbiter, per-channel sram banks and response router
`timescale 1ns/100ps

module tcdm_subsys #(
  parameter int unsigned NB_CHAN = 2,
  parameter int unsigned ADDR_W  = 6   // 64 words per bank
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 invert_prio_i,
  input  tcdm_pkg::stall_cnt_t max_stall_i,

  // hi side requests
  input  logic [NB_CHAN-1:0]   hi_req_i,
  input  logic [ADDR_W-1:0]    hi_add_i  [NB_CHAN],
  input  logic [NB_CHAN-1:0]   hi_wen_i,
  input  tcdm_pkg::be_t        hi_be_i   [NB_CHAN],
  input  tcdm_pkg::data_t      hi_data_i [NB_CHAN],

  // lo side requests
  input  logic [NB_CHAN-1:0]   lo_req_i,
  input  logic [ADDR_W-1:0]    lo_add_i  [NB_CHAN],
  input  logic [NB_CHAN-1:0]   lo_wen_i,
  input  tcdm_pkg::be_t        lo_be_i   [NB_CHAN],
  input  tcdm_pkg::data_t      lo_data_i [NB_CHAN],

  output logic [NB_CHAN-1:0]   hi_gnt_o,
  output logic [NB_CHAN-1:0]   lo_gnt_o,

  // responses, one cycle after grant
  output tcdm_pkg::data_t      hi_r_data_o [NB_CHAN],
  output tcdm_pkg::data_t      lo_r_data_o [NB_CHAN],
  output logic [NB_CHAN-1:0]   hi_r_valid_o,
  output logic [NB_CHAN-1:0]   lo_r_valid_o
);

  // arbiter to banks
  logic [NB_CHAN-1:0] bank_req;
  logic [NB_CHAN-1:0] bank_wen;
  logic [ADDR_W-1:0]  bank_add   [NB_CHAN];
  tcdm_pkg::be_t      bank_be    [NB_CHAN];
  tcdm_pkg::data_t    bank_wdata [NB_CHAN];
  logic [NB_CHAN-1:0] sel_lo;     // winner per channel, to router

  tcdm_pkg::data_t    bank_rdata [NB_CHAN];  // banks to router

  tcdm_arbiter #(
    .NB_CHAN ( NB_CHAN ),
    .ADDR_W  ( ADDR_W  )
  ) u_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .invert_prio_i ( invert_prio_i ),
    .max_stall_i   ( max_stall_i   ),
    .hi_req_i      ( hi_req_i      ),
    .hi_add_i      ( hi_add_i      ),
    .hi_wen_i      ( hi_wen_i      ),
    .hi_be_i       ( hi_be_i       ),
    .hi_data_i     ( hi_data_i     ),
    .lo_req_i      ( lo_req_i      ),
    .lo_add_i      ( lo_add_i      ),
    .lo_wen_i      ( lo_wen_i      ),
    .lo_be_i       ( lo_be_i       ),
    .lo_data_i     ( lo_data_i     ),
    .hi_gnt_o      ( hi_gnt_o      ),
    .lo_gnt_o      ( lo_gnt_o      ),
    .bank_req_o    ( bank_req      ),
    .bank_wen_o    ( bank_wen      ),
    .bank_add_o    ( bank_add      ),
    .bank_be_o     ( bank_be       ),
    .bank_data_o   ( bank_wdata    ),
    .sel_lo_o      ( sel_lo        )
  );

  // one sram bank per channel
  for (genvar c = 0; c < NB_CHAN; c++)
  begin : g_bank
    tcdm_bank #(
      .ADDR_W ( ADDR_W )
    ) u_bank (
      .clk_i    ( clk_i         ),
      .rst_ni   ( rst_ni        ),
      .req_i    ( bank_req[c]   ),
      .wen_i    ( bank_wen[c]   ),
      .add_i    ( bank_add[c]   ),
      .be_i     ( bank_be[c]    ),
      .data_i   ( bank_wdata[c] ),
      .r_data_o ( bank_rdata[c] )
    );
  end

  tcdm_resp_route #(
    .NB_CHAN ( NB_CHAN )
  ) u_resp_route (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .clear_i       ( clear_i      ),
    .bank_req_i    ( bank_req     ),
    .sel_lo_i      ( sel_lo       ),
    .bank_r_data_i ( bank_rdata   ),
    .hi_r_valid_o  ( hi_r_valid_o ),
    .lo_r_valid_o  ( lo_r_valid_o ),
    .hi_r_data_o   ( hi_r_data_o  ),
    .lo_r_data_o   ( lo_r_data_o  )
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// testbench clock source and active-low power-on reset
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 8,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;  // 50% duty
  end

  initial
  begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // release mid-cycle, away from the sampling edge
  end

endmodule

// ==== verif/tb_tcdm_subsys.sv ====
// testbench for the tcdm slice, hi/lo traffic against a reference arbiter and shadow memory
`timescale 1ns/100ps

module tb_tcdm_subsys;

  localparam int unsigned NB_CHAN    = 2;
  localparam int unsigned ADDR_W     = 6;
  localparam int unsigned NB_WORDS   = 2 ** ADDR_W;
  localparam int unsigned CLK_NS     = 8;
  localparam int unsigned DRIVE_DLY  = 1;   // input skew after the rising edge
  localparam int unsigned PRIO_CYC   = 40;
  localparam int unsigned STARVE_CYC = 24;
  localparam int unsigned RAND_CYC   = 60;
  localparam int unsigned RAND_SEGS  = 3;
  localparam int unsigned DRAIN_CYC  = 8;
  // reset, idle, preload, clear test, two arbitration passes, random, drain
  localparam int unsigned TOTAL_CYC  = 4 + 1 + NB_WORDS + 9 + 2 * (PRIO_CYC + STARVE_CYC)
                                     + RAND_SEGS * RAND_CYC + DRAIN_CYC;
  localparam int unsigned WATCHDOG_NS = (TOTAL_CYC + 50) * CLK_NS;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 clear_i;
  logic                 invert_prio_i;
  tcdm_pkg::stall_cnt_t max_stall_i;
  logic [NB_CHAN-1:0]   hi_req_i, hi_wen_i, lo_req_i, lo_wen_i;
  logic [ADDR_W-1:0]    hi_add_i [NB_CHAN];
  logic [ADDR_W-1:0]    lo_add_i [NB_CHAN];
  tcdm_pkg::be_t        hi_be_i [NB_CHAN];
  tcdm_pkg::be_t        lo_be_i [NB_CHAN];
  tcdm_pkg::data_t      hi_data_i [NB_CHAN];
  tcdm_pkg::data_t      lo_data_i [NB_CHAN];
  logic [NB_CHAN-1:0]   hi_gnt_o, lo_gnt_o, hi_r_valid_o, lo_r_valid_o;
  tcdm_pkg::data_t      hi_r_data_o [NB_CHAN];
  tcdm_pkg::data_t      lo_r_data_o [NB_CHAN];

  integer seed;
  int     errors = 0;

  int unsigned          run_len;     // contested cycles won by the priority side
  logic                 yield_ref;   // current cycle is forced to the other side
  logic [NB_CHAN-1:0]   exp_hi_gnt, exp_lo_gnt;
  logic [NB_CHAN-1:0]   exp_hi_vld, exp_lo_vld;
  logic [NB_CHAN-1:0]   rd_pend;     // granted read awaiting its data
  tcdm_pkg::data_t      exp_rdata [NB_CHAN];
  tcdm_pkg::data_t      shadow [NB_CHAN][NB_WORDS];

  tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(4)) u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  tcdm_subsys #(.NB_CHAN(NB_CHAN), .ADDR_W(ADDR_W)) u_dut (
    .clk_i, .rst_ni, .clear_i, .invert_prio_i, .max_stall_i,
    .hi_req_i, .hi_add_i, .hi_wen_i, .hi_be_i, .hi_data_i,
    .lo_req_i, .lo_add_i, .lo_wen_i, .lo_be_i, .lo_data_i,
    .hi_gnt_o, .lo_gnt_o, .hi_r_data_o, .lo_r_data_o, .hi_r_valid_o, .lo_r_valid_o
  );

  function automatic tcdm_pkg::data_t merge_bytes(input tcdm_pkg::data_t old_w,
                                                  input tcdm_pkg::data_t new_w,
                                                  input tcdm_pkg::be_t   be);
    tcdm_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < tcdm_pkg::BE_W; b++)
      if (be[b])
        res[8*b +: 8] = new_w[8*b +: 8];  // enabled bytes only
    return res;
  endfunction

  // preload pattern, every address bit shows up in the word
  function automatic tcdm_pkg::data_t fill_word(input int c, input int a);
    return {8'hc0 | 8'(c), 8'(a), 8'(a) ^ 8'h5a, ~8'(a)};
  endfunction

  task automatic report_value(input string name, input tcdm_pkg::data_t exp_v,
                              input tcdm_pkg::data_t got_v);
    errors++;
    $display("** Error %s: expected %h, got %h at %0t ns", name, exp_v, got_v, $time);
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  // starvation rule: count contested wins, hand over one cycle at the limit
  always @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      run_len   <= 0;
      yield_ref <= 1'b0;
    end
    else if (clear_i || yield_ref || !(|(hi_req_i & lo_req_i)))
    begin
      run_len   <= 0;  // clear, forced cycle or uncontested cycle
      yield_ref <= 1'b0;
    end
    else
    begin
      run_len   <= (run_len == 255) ? 255 : run_len + 1;  // 8-bit saturation
      yield_ref <= (max_stall_i != '0) && (run_len + 1 >= max_stall_i);
    end
  end

  always @*
  begin : ref_grant
    logic p_req;
    logic n_req;
    logic n_win;
    for (int c = 0; c < NB_CHAN; c++)
    begin
      p_req = invert_prio_i ? lo_req_i[c] : hi_req_i[c];
      n_req = invert_prio_i ? hi_req_i[c] : lo_req_i[c];
      n_win = yield_ref || !p_req;  // forced cycle or idle priority side
      exp_hi_gnt[c] = invert_prio_i ? (n_req && n_win) : (p_req && !n_win);
      exp_lo_gnt[c] = invert_prio_i ? (p_req && !n_win) : (n_req && n_win);
    end
  end

  // response expectations, one cycle behind the grant
  always @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      exp_hi_vld <= '0;
      exp_lo_vld <= '0;
      rd_pend    <= '0;
    end
    else
    begin
      exp_hi_vld <= clear_i ? '0 : hi_gnt_o;  // clear drops the pending valid
      exp_lo_vld <= clear_i ? '0 : lo_gnt_o;
      for (int c = 0; c < NB_CHAN; c++)
      begin
        rd_pend[c]   <= !clear_i && ((hi_gnt_o[c] && !hi_wen_i[c]) ||
                                     (lo_gnt_o[c] && !lo_wen_i[c]));
        exp_rdata[c] <= hi_gnt_o[c] ? shadow[c][hi_add_i[c]] : shadow[c][lo_add_i[c]];
      end
    end
  end

  always @(posedge clk_i)
  begin
    for (int c = 0; c < NB_CHAN; c++)
    begin
      if (hi_gnt_o[c] && hi_wen_i[c])
        shadow[c][hi_add_i[c]] <= merge_bytes(shadow[c][hi_add_i[c]], hi_data_i[c], hi_be_i[c]);
      if (lo_gnt_o[c] && lo_wen_i[c])
        shadow[c][lo_add_i[c]] <= merge_bytes(shadow[c][lo_add_i[c]], lo_data_i[c], lo_be_i[c]);
    end
  end

  a_quiet_reset : assert property (@(posedge clk_i) (!rst_ni || $rose(rst_ni)) |->
    ((hi_gnt_o | lo_gnt_o | hi_r_valid_o | lo_r_valid_o) == '0))
    else report_fail("grant or response valid high in or right after reset");

  a_hi_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni) hi_gnt_o == exp_hi_gnt)
    else report_value("hi_gnt_o", $sampled(exp_hi_gnt), $sampled(hi_gnt_o));

  a_lo_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni) lo_gnt_o == exp_lo_gnt)
    else report_value("lo_gnt_o", $sampled(exp_lo_gnt), $sampled(lo_gnt_o));

  a_yield_side : assert property (@(posedge clk_i) disable iff (!rst_ni)
    yield_ref |-> ((invert_prio_i ? lo_gnt_o : hi_gnt_o) == '0))
    else report_fail("priority side granted in a forced yield cycle");

  a_hi_vld : assert property (@(posedge clk_i) disable iff (!rst_ni) hi_r_valid_o == exp_hi_vld)
    else report_value("hi_r_valid_o", $sampled(exp_hi_vld), $sampled(hi_r_valid_o));

  a_lo_vld : assert property (@(posedge clk_i) disable iff (!rst_ni) lo_r_valid_o == exp_lo_vld)
    else report_value("lo_r_valid_o", $sampled(exp_lo_vld), $sampled(lo_r_valid_o));

  for (genvar c = 0; c < NB_CHAN; c++)
  begin : g_chan_chk
    tcdm_pkg::data_t got_rdata;
    assign got_rdata = hi_r_valid_o[c] ? hi_r_data_o[c] : lo_r_data_o[c];

    // guard off for two cycles, so no yield can be pending
    a_fixed_prio : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (max_stall_i == '0 && $past(max_stall_i) == '0 && hi_req_i[c] && lo_req_i[c]) |->
        (invert_prio_i ? (lo_gnt_o[c] && !hi_gnt_o[c]) : (hi_gnt_o[c] && !lo_gnt_o[c])))
      else report_fail($sformatf("priority side not the only winner on channel %0d", c));

    a_rdata : assert property (@(posedge clk_i) disable iff (!rst_ni)
      rd_pend[c] |-> (got_rdata == exp_rdata[c]))
      else report_value($sformatf("%s_r_data_o[%0d]", $sampled(hi_r_valid_o[c]) ? "hi" : "lo", c),
                        $sampled(exp_rdata[c]), $sampled(got_rdata));
  end

  // close the current cycle, return its grants, step to the next drive point
  task automatic end_cycle(output logic [NB_CHAN-1:0] hi_g, output logic [NB_CHAN-1:0] lo_g);
    @(negedge clk_i);
    hi_g = hi_gnt_o;
    lo_g = lo_gnt_o;
    @(posedge clk_i);
    #(DRIVE_DLY);
  endtask

  task automatic pick_req(input bit lo_side, input int c, input int unsigned pct);
    logic req;
    req = ({$random(seed)} % 100) < pct;
    if (lo_side)
    begin
      lo_req_i[c]  = req;
      lo_wen_i[c]  = $random(seed);
      lo_add_i[c]  = $random(seed);
      lo_be_i[c]   = $random(seed);
      lo_data_i[c] = $random(seed);
    end
    else
    begin
      hi_req_i[c]  = req;
      hi_wen_i[c]  = $random(seed);
      hi_add_i[c]  = $random(seed);
      hi_be_i[c]   = $random(seed);
      hi_data_i[c] = $random(seed);
    end
  endtask

  // requests stay up until granted, then a fresh one may follow
  task automatic run_traffic(input int unsigned n_cyc, input int unsigned hi_pct,
                             input int unsigned lo_pct);
    logic [NB_CHAN-1:0] hi_g;
    logic [NB_CHAN-1:0] lo_g;
    for (int unsigned i = 0; i < n_cyc; i++)
    begin
      end_cycle(hi_g, lo_g);
      for (int c = 0; c < NB_CHAN; c++)
      begin
        if (!hi_req_i[c] || hi_g[c])
          pick_req(1'b0, c, hi_pct);
        if (!lo_req_i[c] || lo_g[c])
          pick_req(1'b1, c, lo_pct);
      end
    end
  endtask

  task automatic fill_banks();
    logic [NB_CHAN-1:0] hi_g;
    logic [NB_CHAN-1:0] lo_g;
    for (int a = 0; a < NB_WORDS; a++)
    begin
      for (int c = 0; c < NB_CHAN; c++)
      begin
        hi_req_i[c]  = 1'b1;
        hi_wen_i[c]  = 1'b1;
        hi_add_i[c]  = a;
        hi_be_i[c]   = '1;  // full word
        hi_data_i[c] = fill_word(c, a);
      end
      do
        end_cycle(hi_g, lo_g);
      while (hi_g != '1);
    end
    hi_req_i = '0;
  endtask

  initial
  begin
    seed          = 32'h5fd7b88b;
    clear_i       = 1'b0;
    invert_prio_i = 1'b0;
    max_stall_i   = '0;
    hi_req_i      = '0;
    hi_wen_i      = '0;
    lo_req_i      = '0;
    lo_wen_i      = '0;
    for (int c = 0; c < NB_CHAN; c++)
    begin
      hi_add_i[c]  = '0;
      lo_add_i[c]  = '0;
      hi_be_i[c]   = '0;
      lo_be_i[c]   = '0;
      hi_data_i[c] = '0;
      lo_data_i[c] = '0;
    end
    wait (rst_ni === 1'b1);
    @(posedge clk_i);  // first cycle out of reset stays idle
    #(DRIVE_DLY);

    // reset and clear: preload, then clear pulse mid contention
    fill_banks();
    max_stall_i = 8'd3;
    run_traffic(2, 100, 100);
    clear_i = 1'b1;
    run_traffic(1, 100, 100);
    clear_i = 1'b0;
    run_traffic(6, 100, 100);

    max_stall_i = '0;  // fixed priority
    run_traffic(PRIO_CYC, 80, 80);
    max_stall_i = 8'd3;  // starvation guard, 1 in 4
    run_traffic(STARVE_CYC, 100, 100);

    invert_prio_i = 1'b1;  // same two passes, roles swapped
    max_stall_i   = '0;
    run_traffic(PRIO_CYC, 80, 80);
    max_stall_i   = 8'd3;
    run_traffic(STARVE_CYC, 100, 100);

    for (int s = 0; s < RAND_SEGS; s++)
    begin
      invert_prio_i = $random(seed);
      max_stall_i   = {$random(seed)} % 5;
      run_traffic(RAND_CYC, 30 + {$random(seed)} % 60, 30 + {$random(seed)} % 60);
    end
    run_traffic(DRAIN_CYC, 0, 0);  // let held requests finish

    $display("tb_tcdm_subsys done, %0d errors", errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns, %0d errors so far", WATCHDOG_NS, errors);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== tcdm_subsys.f ====
logic/tcdm_pkg.sv
logic/tcdm_arbiter.sv
logic/tcdm_bank.sv
logic/tcdm_resp_route.sv
logic/tcdm_subsys.sv
verif/tb_clk_gen.sv
verif/tb_tcdm_subsys.sv

// ==== Bender.yml ====
package:
  name: tcdm_subsys

sources:
  # package first, then leaf modules, then the top level
  - logic/tcdm_pkg.sv
  - logic/tcdm_arbiter.sv
  - logic/tcdm_bank.sv
  - logic/tcdm_resp_route.sv
  - logic/tcdm_subsys.sv

  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_tcdm_subsys.sv
